//--- design/pin_cfg_decode.sv
module pin_cfg_decode #(
  parameter int num_pins = 23
) (
  input  logic                                    wMEM_CLK,
  input  logic                                    reset,
  input  logic                                    cfg_wr,        // one pin per strobe
  input  pin_cfg_pkg::pin_idx_t                   cfg_pin,
  input  pin_cfg_pkg::pin_mode_t                  cfg_mode,
  input  logic                                    cfg_dir,       // 1 drives in gpio mode
  input  logic                                    cfg_out,
  output logic [pin_cfg_pkg::mode_w*num_pins-1:0] mode_vec,      // two bits per pin
  output logic [num_pins-1:0]                     dir_vec,
  output logic [num_pins-1:0]                     gpio_out_vec,
  output logic                                    ready          // bank live
);

  localparam int cnt_w = $clog2(pin_cfg_pkg::stretch_len);

  // stretcher runs once after reset, then stays live
  typedef enum logic
  {
    ST_STRETCH = 1'b0,
    ST_LIVE    = 1'b1
  } cfg_state_t;

  cfg_state_t       state;
  logic [cnt_w-1:0] stretch_cnt;  // edges seen since reset fell
  logic             cfg_hit;      // write accepted this edge

  assign ready = (state == ST_LIVE);

  // out of range pin numbers fall on the floor
  assign cfg_hit = cfg_wr && ready && (int'(cfg_pin) < num_pins);

  // reset stretcher
  always_ff @(posedge wMEM_CLK)
  begin
    if (reset)
    begin
      state       <= ST_STRETCH;
      stretch_cnt <= '0;
    end
    else if (state == ST_STRETCH)
    begin
      stretch_cnt <= stretch_cnt + 1'b1;
      if (stretch_cnt == cnt_w'(pin_cfg_pkg::stretch_len - 1))
        state <= ST_LIVE;  // ready high after this edge
    end
  end

  // per-pin config, gpio input with out low after reset
  always_ff @(posedge wMEM_CLK)
  begin
    if (reset)
    begin
      mode_vec     <= {num_pins{pin_cfg_pkg::PIN_GPIO}};
      dir_vec      <= '0;  // all inputs
      gpio_out_vec <= '0;
    end
    else if (cfg_hit)
    begin
      mode_vec[cfg_pin*pin_cfg_pkg::mode_w +: pin_cfg_pkg::mode_w] <= cfg_mode;
      dir_vec[cfg_pin]      <= cfg_dir;
      gpio_out_vec[cfg_pin] <= cfg_out;
    end
  end

endmodule

//--- design/pin_cfg_pkg.sv
package pin_cfg_pkg;

  localparam int max_pins    = 32;  // widest header bank handled
  localparam int stretch_len = 32;  // wMEM_CLK edges before the bank goes live

  // function select held per header pin
  typedef enum logic [1:0]
  {
    PIN_GPIO  = 2'd0,  // plain gpio from dir and out bits
    PIN_PWM   = 2'd1,  // pwm block drives the pin
    PIN_I2C   = 2'd2,  // i2c buses 0 to 2
    PIN_LANES = 2'd3   // i2c3, spi masters and npix
  } pin_mode_t;

  localparam int mode_w = $bits(pin_mode_t);  // bits per pin in mode_vec

  typedef logic [$clog2(max_pins)-1:0] pin_idx_t;  // pin number on the config port

endpackage

//--- design/pin_drive_stage.sv
module pin_drive_stage #(
  parameter int num_pins = 23
) (
  input  logic                wMEM_CLK,
  input  logic                reset,
  input  logic [num_pins-1:0] sel_out,  // from pin_func_select
  input  logic [num_pins-1:0] sel_oe,
  input  logic [num_pins-1:0] pin_in,   // raw header levels, async
  output logic [num_pins-1:0] pin_out,
  output logic [num_pins-1:0] pin_oe,   // 1 drives pin_out onto the pin
  output logic [num_pins-1:0] gpio_in
);

  logic [num_pins-1:0] pin_in_meta;  // first sync flop

  // output register, pins float while in reset
  always_ff @(posedge wMEM_CLK)
  begin
    if (reset)
    begin
      pin_out <= '0;
      pin_oe  <= '0;
    end
    else
    begin
      pin_out <= sel_out;
      pin_oe  <= sel_oe;
    end
  end

  // two flop synchronizer on the header inputs
  always_ff @(posedge wMEM_CLK)
  begin
    pin_in_meta <= pin_in;
    gpio_in     <= pin_in_meta;  // two edges behind pin_in
  end

endmodule

//--- design/pin_func_select.sv
module pin_func_select #(
  parameter int num_pins = 23
) (
  input  logic [pin_cfg_pkg::mode_w*num_pins-1:0] mode_vec,
  input  logic [num_pins-1:0]                     dir_vec,
  input  logic [num_pins-1:0]                     gpio_out_vec,
  input  logic [num_pins-1:0]                     pwm,          // one pwm channel per pin
  input  pin_map_pkg::i2c_vec_t                   i2c_out,
  input  pin_map_pkg::i2c_vec_t                   i2c_en,
  input  pin_map_pkg::spi_vec_t                   spi_mosi,
  input  pin_map_pkg::spi_vec_t                   spi_sck,
  input  pin_map_pkg::spi_vec_t                   spi_cs,
  input  pin_map_pkg::npix_vec_t                  npix,
  input  pin_map_pkg::byp_vec_t                   nina_bypass,  // radio owns the pin
  input  pin_map_pkg::byp_vec_t                   nina_in,
  output logic [num_pins-1:0]                     sel_out,
  output logic [num_pins-1:0]                     sel_oe
);

  logic [pin_map_pkg::lane_w-1:0] lane_bus;  // lane mode sources in slot order
  logic [pin_map_pkg::lane_w-1:0] lane_en;   // enable for each slot

  // i2c bus 3 sits in the top two bits of the i2c vectors
  assign lane_bus = {npix, spi_cs, spi_sck, spi_mosi, i2c_out[7:6]};
  assign lane_en  = {{(pin_map_pkg::lane_w - 2){1'b1}}, i2c_en[7:6]};

  for (genvar p = 0; p < num_pins; p++)
  begin : g_pin
    localparam int lane_i  = pin_map_pkg::lane_slot(p);
    localparam int i2c_i   = pin_map_pkg::i2c_slot(p);
    localparam int byp_i   = pin_map_pkg::byp_slot(p);
    localparam bit idle_oe = (p != 0);  // pin 0 floats in i2c and lane modes

    pin_cfg_pkg::pin_mode_t mode;
    logic                   lane_o;
    logic                   lane_e;
    logic                   i2c_o;
    logic                   i2c_e;
    logic                   byp_on;
    logic                   byp_o;
    logic                   pin_o;
    logic                   pin_e;

    assign mode = pin_cfg_pkg::pin_mode_t'(
                    mode_vec[p*pin_cfg_pkg::mode_w +: pin_cfg_pkg::mode_w]);

    if (lane_i >= 0)
    begin : g_lane
      assign lane_o = lane_bus[lane_i];
      assign lane_e = lane_en[lane_i];  // from i2c_en on pins 1 and 2
    end
    else
    begin : g_no_lane
      assign lane_o = 1'b0;
      assign lane_e = idle_oe;
    end

    if (i2c_i >= 0)
    begin : g_i2c
      assign i2c_o = i2c_out[i2c_i];
      assign i2c_e = i2c_en[i2c_i];
    end
    else
    begin : g_no_i2c
      assign i2c_o = 1'b0;
      assign i2c_e = idle_oe;
    end

    if (byp_i >= 0)
    begin : g_byp
      assign byp_on = nina_bypass[byp_i];
      assign byp_o  = nina_in[byp_i];
    end
    else
    begin : g_no_byp
      assign byp_on = 1'b0;  // pin has no radio lane
      assign byp_o  = 1'b0;
    end

    always_comb
    begin
      case (mode)
        pin_cfg_pkg::PIN_GPIO:
        begin
          if (byp_on)
          begin
            pin_o = byp_o;  // radio passthrough
            pin_e = 1'b1;
          end
          else
          begin
            pin_o = gpio_out_vec[p];
            pin_e = dir_vec[p];
          end
        end
        pin_cfg_pkg::PIN_PWM:
        begin
          pin_o = pwm[p];
          pin_e = 1'b1;
        end
        pin_cfg_pkg::PIN_I2C:
        begin
          pin_o = i2c_o;
          pin_e = i2c_e;
        end
        default:
        begin
          pin_o = lane_o;  // lane mode
          pin_e = lane_e;
        end
      endcase
    end

    assign sel_out[p] = pin_o;
    assign sel_oe[p]  = pin_e;
  end

endmodule

//--- design/pin_map_pkg.sv
package pin_map_pkg;

  typedef logic [7:0] i2c_vec_t;   // bit 2n scl, bit 2n+1 sda of bus n
  typedef logic [4:0] spi_vec_t;   // one bit per spi master
  typedef logic [4:0] npix_vec_t;  // pixel data
  typedef logic [2:0] byp_vec_t;   // radio bypass lanes

  // bypass lane bits
  localparam int byp_miso = 0;
  localparam int byp_tx   = 1;
  localparam int byp_ack  = 2;

  // header pins the radio can take over in gpio mode
  localparam int byp_pin_miso = 18;  // radio miso back to sam
  localparam int byp_pin_tx   = 21;  // radio uart tx
  localparam int byp_pin_ack  = 12;  // handshake ack from radio

  localparam int i2c_first_pin = 16;  // i2c bit 0 lands here
  localparam int i2c_mux_bits  = 6;   // buses 0 to 2, scl and sda

  localparam int min_pins = 23;  // last lane pin is 22

  // slot offsets on the lane bus built in pin_func_select
  localparam int lane_i2c3 = 0;   // scl then sda
  localparam int lane_mosi = 2;
  localparam int lane_sck  = 7;
  localparam int lane_cs   = 12;
  localparam int lane_npix = 17;
  localparam int lane_w    = 22;

  // lane bus slot feeding a pin in lane mode, -1 when none
  function automatic int lane_slot(int pin);
    int slot;
    slot = -1;
    if (pin > 0 && pin < min_pins)
    begin
      case (pin)
        1:  slot = lane_i2c3;
        2:  slot = lane_i2c3 + 1;
        3:  slot = lane_mosi;
        4:  slot = lane_sck;
        5:  slot = lane_cs;
        6:  slot = lane_mosi + 1;
        7:  slot = lane_npix;
        8:  slot = lane_npix + 1;
        9:  slot = lane_sck + 1;
        10: slot = lane_cs + 1;
        11: slot = lane_mosi + 2;
        12: slot = lane_sck + 2;
        13: slot = lane_cs + 2;
        14: slot = lane_mosi + 3;
        15: slot = lane_npix + 2;
        16: slot = lane_npix + 3;
        17: slot = lane_sck + 3;
        18: slot = lane_cs + 3;
        19: slot = lane_mosi + 4;
        20: slot = lane_npix + 4;
        21: slot = lane_sck + 4;
        22: slot = lane_cs + 4;
        default: slot = -1;
      endcase
    end
    return slot;
  endfunction

  // i2c_out bit feeding a pin in i2c mode, -1 when none
  function automatic int i2c_slot(int pin);
    int slot;
    slot = -1;
    if (pin >= i2c_first_pin && pin < i2c_first_pin + i2c_mux_bits)
      slot = pin - i2c_first_pin;
    return slot;
  endfunction

  // bypass lane owning a pin, -1 when none
  function automatic int byp_slot(int pin);
    int slot;
    case (pin)
      byp_pin_miso: slot = byp_miso;
      byp_pin_tx:   slot = byp_tx;
      byp_pin_ack:  slot = byp_ack;
      default:      slot = -1;
    endcase
    return slot;
  endfunction

endpackage

//--- design/sam_pin_mux_top.sv
module sam_pin_mux_top #(
  parameter int num_pins = 23  // 23 to 32
) (
  input  logic                   wMEM_CLK,
  input  logic                   reset,
  input  logic                   cfg_wr,
  input  pin_cfg_pkg::pin_idx_t  cfg_pin,
  input  pin_cfg_pkg::pin_mode_t cfg_mode,
  input  logic                   cfg_dir,
  input  logic                   cfg_out,
  input  logic [num_pins-1:0]    pwm,
  input  pin_map_pkg::i2c_vec_t  i2c_out,
  input  pin_map_pkg::i2c_vec_t  i2c_en,
  input  pin_map_pkg::spi_vec_t  spi_mosi,
  input  pin_map_pkg::spi_vec_t  spi_sck,
  input  pin_map_pkg::spi_vec_t  spi_cs,
  input  pin_map_pkg::npix_vec_t npix,
  input  pin_map_pkg::byp_vec_t  nina_bypass,
  input  pin_map_pkg::byp_vec_t  nina_in,
  input  logic [num_pins-1:0]    pin_in,
  output logic [num_pins-1:0]    pin_out,
  output logic [num_pins-1:0]    pin_oe,
  output logic [num_pins-1:0]    gpio_in,
  output logic                   ready
);

  logic [pin_cfg_pkg::mode_w*num_pins-1:0] mode_vec;  // per-pin function select
  logic [num_pins-1:0]                     dir_vec;
  logic [num_pins-1:0]                     gpio_out_vec;
  logic [num_pins-1:0]                     sel_out;   // unregistered pin drive
  logic [num_pins-1:0]                     sel_oe;

  pin_cfg_decode #(
    .num_pins     (num_pins)
  ) pin_cfg_decode_inst (
    .wMEM_CLK     (wMEM_CLK),
    .reset        (reset),
    .cfg_wr       (cfg_wr),
    .cfg_pin      (cfg_pin),
    .cfg_mode     (cfg_mode),
    .cfg_dir      (cfg_dir),
    .cfg_out      (cfg_out),
    .mode_vec     (mode_vec),
    .dir_vec      (dir_vec),
    .gpio_out_vec (gpio_out_vec),
    .ready        (ready)
  );

  pin_func_select #(
    .num_pins     (num_pins)
  ) pin_func_select_inst (
    .mode_vec     (mode_vec),
    .dir_vec      (dir_vec),
    .gpio_out_vec (gpio_out_vec),
    .pwm          (pwm),
    .i2c_out      (i2c_out),
    .i2c_en       (i2c_en),
    .spi_mosi     (spi_mosi),
    .spi_sck      (spi_sck),
    .spi_cs       (spi_cs),
    .npix         (npix),
    .nina_bypass  (nina_bypass),
    .nina_in      (nina_in),
    .sel_out      (sel_out),
    .sel_oe       (sel_oe)
  );

  pin_drive_stage #(
    .num_pins     (num_pins)
  ) pin_drive_stage_inst (
    .wMEM_CLK     (wMEM_CLK),
    .reset        (reset),
    .sel_out      (sel_out),
    .sel_oe       (sel_oe),
    .pin_in       (pin_in),
    .pin_out      (pin_out),
    .pin_oe       (pin_oe),
    .gpio_in      (gpio_in)
  );

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the pin mux testbench with verilator, result taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module tb_sam_pin_mux -f vlog.f > sim.log 2>&1 \
  && ./obj_dir/Vtb_sam_pin_mux >> sim.log 2>&1 \
  || { cat sim.log; echo "build or run failed"; exit 1; }
cat sim.log
grep -q "ERRORS FOUND" sim.log && { echo "simulation reported failures"; exit 1; }
grep -q "NO ERRORS" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0

//--- test/pin_mux_checker.sv
module pin_mux_checker #(
  parameter int num_pins = 23
) (
  input  logic                   wMEM_CLK,
  input  logic                   reset,
  input  logic                   cfg_wr,
  input  pin_cfg_pkg::pin_idx_t  cfg_pin,
  input  pin_cfg_pkg::pin_mode_t cfg_mode,
  input  logic                   cfg_dir,
  input  logic                   cfg_out,
  input  logic [num_pins-1:0]    pwm,
  input  pin_map_pkg::i2c_vec_t  i2c_out,
  input  pin_map_pkg::i2c_vec_t  i2c_en,
  input  pin_map_pkg::spi_vec_t  spi_mosi,
  input  pin_map_pkg::spi_vec_t  spi_sck,
  input  pin_map_pkg::spi_vec_t  spi_cs,
  input  pin_map_pkg::npix_vec_t npix,
  input  pin_map_pkg::byp_vec_t  nina_bypass,
  input  pin_map_pkg::byp_vec_t  nina_in,
  input  logic [num_pins-1:0]    pin_in,
  input  logic [num_pins-1:0]    pin_out,
  input  logic [num_pins-1:0]    pin_oe,
  input  logic [num_pins-1:0]    gpio_in,
  input  logic                   ready,
  input  int                     test_num,    // stimulus row now applied
  input  logic [8*8-1:0]         test_label,
  output int                     err_total,
  output int                     chk_total
);

  localparam int stretch_edges = 32;  // edges from reset low to ready

  pin_cfg_pkg::pin_mode_t m_mode [num_pins];  // config mirrored from the write port
  logic [num_pins-1:0]    m_dir;
  logic [num_pins-1:0]    m_out;
  logic [num_pins-1:0]    exp_out;    // due after the next edge
  logic [num_pins-1:0]    exp_oe;
  logic [num_pins-1:0]    in_d1;      // pin_in one and two edges back
  logic [num_pins-1:0]    in_d2;
  logic [22:0]            lane_o;     // lane mode drive, pin 22 down to pin 0
  logic [22:0]            lane_e;
  logic                   exp_ready;
  logic [8*8-1:0]         cur_label;
  int stretch  = 0;
  int edges    = 0;
  int cur_num  = -1;
  int test_chk = 0;
  int test_err = 0;
  int n_err    = 0;
  int n_chk    = 0;

  assign err_total = n_err;
  assign chk_total = n_chk;

  // board order, spi4 cs on top and i2c3 on pins 1 and 2
  assign lane_o = {spi_cs[4], spi_sck[4], npix[4], spi_mosi[4],
                   spi_cs[3], spi_sck[3], npix[3], npix[2], spi_mosi[3],
                   spi_cs[2], spi_sck[2], spi_mosi[2],
                   spi_cs[1], spi_sck[1], npix[1], npix[0], spi_mosi[1],
                   spi_cs[0], spi_sck[0], spi_mosi[0],
                   i2c_out[7], i2c_out[6], 1'b0};
  assign lane_e = {{20{1'b1}}, i2c_en[7:6], 1'b0};  // pin 0 floats

  task automatic compare_value(input string name, input logic [num_pins-1:0] exp_v,
                               input logic [num_pins-1:0] got_v);
    n_chk++;
    test_chk++;
    if (got_v !== exp_v)
    begin
      $display("error at %0t: %s expected %h got %h", $time, name, exp_v, got_v);
      n_err++;
      test_err++;
    end
  endtask

  // outputs seen here were registered on the previous edge
  always @(posedge wMEM_CLK)
  begin
    logic byp_hit;
    logic byp_lvl;
    if (test_num != cur_num)
    begin
      if (cur_num >= 0)
        $display("test %0d %s: %0d checks, %0d errors", cur_num, cur_label, test_chk, test_err);
      cur_num   = test_num;
      cur_label = test_label;
      test_chk  = 0;
      test_err  = 0;
    end
    if (edges >= 1)
    begin
      compare_value("pin_out", exp_out, pin_out);
      compare_value("pin_oe", exp_oe, pin_oe);
      compare_value("ready", num_pins'(exp_ready), num_pins'(ready));
    end
    if (edges >= 2)
      compare_value("gpio_in", in_d2, gpio_in);
    if (reset)
    begin
      exp_out   = '0;  // bank floats through reset
      exp_oe    = '0;
      m_dir     = '0;
      m_out     = '0;
      stretch   = 0;
      exp_ready = 1'b0;
      for (int p = 0; p < num_pins; p++)
        m_mode[p] = pin_cfg_pkg::PIN_GPIO;
    end
    else
    begin
      for (int p = 0; p < num_pins; p++)
      begin
        byp_hit = (p == 18) ? nina_bypass[0] : (p == 21) ? nina_bypass[1] :
                  (p == 12) ? nina_bypass[2] : 1'b0;
        byp_lvl = (p == 18) ? nina_in[0] : (p == 21) ? nina_in[1] : nina_in[2];
        case (m_mode[p])
          pin_cfg_pkg::PIN_GPIO:
          begin
            exp_oe[p]  = byp_hit | m_dir[p];  // radio takes the pin
            exp_out[p] = byp_hit ? byp_lvl : m_out[p];
          end
          pin_cfg_pkg::PIN_PWM:
          begin
            exp_oe[p]  = 1'b1;
            exp_out[p] = pwm[p];
          end
          pin_cfg_pkg::PIN_I2C:
          begin
            exp_oe[p]  = (p >= 16 && p <= 21) ? i2c_en[p-16] : (p != 0);
            exp_out[p] = (p >= 16 && p <= 21) ? i2c_out[p-16] : 1'b0;
          end
          default:
          begin
            exp_oe[p]  = (p < 23) ? lane_e[p] : 1'b1;  // unmapped pins drive low
            exp_out[p] = (p < 23) ? lane_o[p] : 1'b0;
          end
        endcase
      end
      if (cfg_wr && exp_ready && int'(cfg_pin) < num_pins)
      begin
        m_mode[cfg_pin] = cfg_mode;
        m_dir[cfg_pin]  = cfg_dir;
        m_out[cfg_pin]  = cfg_out;
      end
      if (stretch < stretch_edges)
        stretch++;
      exp_ready = (stretch == stretch_edges);
    end
    in_d2 = in_d1;
    in_d1 = pin_in;
    edges++;
  end

endmodule

//--- test/tb_sam_pin_mux.sv
module tb_sam_pin_mux;

  localparam int num_pins = 23;
  localparam int n_rows   = 9;
  localparam int hold_cyc = 3;    // quiet cycles after a row's writes
  localparam int max_wait = 100;  // cycles allowed for ready

  // pins first..last get the same config, one write per cycle
  typedef struct packed
  {
    logic [4:0]             first;
    logic [4:0]             last;
    pin_cfg_pkg::pin_mode_t mode;
    logic                   dir;
    logic                   out;
    pin_map_pkg::byp_vec_t  byp;    // nina_bypass for the whole row
    logic [8*8-1:0]         label;
  } row_t;

  logic                   wMEM_CLK;
  logic                   reset;
  logic                   cfg_wr;
  pin_cfg_pkg::pin_idx_t  cfg_pin;
  pin_cfg_pkg::pin_mode_t cfg_mode;
  logic                   cfg_dir;
  logic                   cfg_out;
  logic [num_pins-1:0]    pwm;
  pin_map_pkg::i2c_vec_t  i2c_out;
  pin_map_pkg::i2c_vec_t  i2c_en;
  pin_map_pkg::spi_vec_t  spi_mosi;
  pin_map_pkg::spi_vec_t  spi_sck;
  pin_map_pkg::spi_vec_t  spi_cs;
  pin_map_pkg::npix_vec_t npix;
  pin_map_pkg::byp_vec_t  nina_bypass;
  pin_map_pkg::byp_vec_t  nina_in;
  logic [num_pins-1:0]    pin_in;
  logic [num_pins-1:0]    pin_out;
  logic [num_pins-1:0]    pin_oe;
  logic [num_pins-1:0]    gpio_in;
  logic                   ready;
  int                     test_num;
  logic [8*8-1:0]         test_label;
  int                     err_total;
  int                     chk_total;
  int                     seed = 3379;
  row_t                   rows [n_rows];

  sam_pin_mux_top #(.num_pins(num_pins)) sam_pin_mux_top_inst (.*);
  pin_mux_checker #(.num_pins(num_pins)) pin_mux_checker_inst (.*);

  initial
  begin
    rows[0] = '{5'd0,  5'd22, pin_cfg_pkg::PIN_GPIO,  1'b1, 1'b1, 3'b000, "gpio_drv"};
    rows[1] = '{5'd0,  5'd11, pin_cfg_pkg::PIN_GPIO,  1'b0, 1'b1, 3'b000, "gpio_in "};
    rows[2] = '{5'd23, 5'd31, pin_cfg_pkg::PIN_PWM,   1'b1, 1'b1, 3'b000, "bad_pin "};
    rows[3] = '{5'd0,  5'd22, pin_cfg_pkg::PIN_PWM,   1'b0, 1'b0, 3'b111, "pwm_all "};
    rows[4] = '{5'd0,  5'd22, pin_cfg_pkg::PIN_I2C,   1'b0, 1'b0, 3'b111, "i2c_all "};
    rows[5] = '{5'd0,  5'd22, pin_cfg_pkg::PIN_LANES, 1'b0, 1'b0, 3'b000, "lane_all"};
    rows[6] = '{5'd12, 5'd12, pin_cfg_pkg::PIN_LANES, 1'b0, 1'b0, 3'b111, "byp_lane"};
    rows[7] = '{5'd0,  5'd22, pin_cfg_pkg::PIN_GPIO,  1'b0, 1'b1, 3'b111, "byp_gpio"};
    rows[8] = '{5'd18, 5'd21, pin_cfg_pkg::PIN_GPIO,  1'b1, 1'b0, 3'b101, "byp_part"};
  end

  initial
  begin
    wMEM_CLK = 1'b0;
    forever #10 wMEM_CLK = ~wMEM_CLK;
  end

  // fresh function inputs and header levels
  task automatic scramble_inputs();
    pwm      = num_pins'($random(seed));
    i2c_out  = 8'($random(seed));
    i2c_en   = 8'($random(seed));
    spi_mosi = 5'($random(seed));
    spi_sck  = 5'($random(seed));
    spi_cs   = 5'($random(seed));
    npix     = 5'($random(seed));
    nina_in  = 3'($random(seed));
    pin_in   = num_pins'($random(seed));
  endtask

  task automatic next_cycle();
    @(posedge wMEM_CLK);
    #2;  // inputs move just after the edge
  endtask

  task automatic apply_rows();
    for (int r = 0; r < n_rows; r++)
    begin
      test_num    = r + 2;
      test_label  = rows[r].label;
      nina_bypass = rows[r].byp;
      for (int p = int'(rows[r].first); p <= int'(rows[r].last); p++)
      begin
        cfg_wr   = 1'b1;
        cfg_pin  = pin_cfg_pkg::pin_idx_t'(p);
        cfg_mode = rows[r].mode;
        cfg_dir  = rows[r].dir;
        cfg_out  = rows[r].out;
        scramble_inputs();
        next_cycle();
      end
      cfg_wr = 1'b0;
      repeat (hold_cyc)
      begin
        scramble_inputs();
        next_cycle();
      end
    end
  endtask

  initial
  begin
    int wait_cnt;
    reset       = 1'b1;
    cfg_wr      = 1'b0;
    cfg_pin     = '0;
    cfg_mode    = pin_cfg_pkg::PIN_GPIO;
    cfg_dir     = 1'b0;
    cfg_out     = 1'b0;
    nina_bypass = '0;
    test_num    = 0;
    test_label  = "reset   ";
    scramble_inputs();
    repeat (16) next_cycle();
    reset      = 1'b0;
    test_num   = 1;
    test_label = "stretch ";
    cfg_wr     = 1'b1;  // early write, dropped until ready
    cfg_pin    = 5'd3;
    cfg_mode   = pin_cfg_pkg::PIN_PWM;
    cfg_dir    = 1'b1;
    cfg_out    = 1'b1;
    for (wait_cnt = 0; wait_cnt < max_wait && ready !== 1'b1; wait_cnt++)
    begin
      scramble_inputs();
      next_cycle();
    end
    cfg_wr = 1'b0;
    if (ready !== 1'b1)
    begin
      $display("timeout: ready still low %0d cycles after reset", max_wait);
      $display("ERRORS FOUND");
    end
    else
    begin
      apply_rows();
      test_num   = n_rows + 2;  // closes the last row's line
      test_label = "end     ";
      repeat (2) next_cycle();
      $display("total: %0d checks, %0d errors", chk_total, err_total);
      if (err_total == 0 && chk_total > 0)
        $display("NO ERRORS");
      else
        $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- vlog.f
design/pin_cfg_pkg.sv
design/pin_map_pkg.sv
design/pin_cfg_decode.sv
design/pin_func_select.sv
design/pin_drive_stage.sv
design/sam_pin_mux_top.sv
test/pin_mux_checker.sv
test/tb_sam_pin_mux.sv
